// File: verilog/noc_pkg.sv
package noc_pkg;

    localparam int FLIT_SIZE   = 32;
    localparam int HEADER_SIZE = 13;

    typedef logic [FLIT_SIZE-1:0] flit_t;
    typedef flit_t [HEADER_SIZE-1:0] header_t;

    // Header flit positions
    localparam int HDR_TARGET      = 0;
    localparam int HDR_SIZE        = 1;   // Flits after this one
    localparam int HDR_SERVICE     = 2;
    localparam int HDR_TASK_ID     = 3;
    localparam int HDR_MAPPER_ADDR = 4;
    localparam int HDR_MAPPER_ID   = 8;
    localparam int HDR_DATA_SZ     = 9;
    localparam int HDR_TEXT_SZ     = 10;
    localparam int HDR_BSS_SZ      = 11;
    localparam int HDR_ENTRY       = 12;

    localparam flit_t MESSAGE_DELIVERY = 32'h1;
    localparam flit_t TASK_ALLOCATION  = 32'h40;

    // Forward half of a link with credit running back
    typedef struct packed {
        logic  tx;
        flit_t data;
    } noc_link_t;

endpackage

// File: verilog/injector_pkg.sv
package injector_pkg;

    // First payload word of a mapper delivery
    localparam noc_pkg::flit_t APP_ALLOCATION_REQUEST = 32'h240;
    localparam noc_pkg::flit_t APP_MAPPING_COMPLETE   = 32'h241;

    // Word offered by the application source
    typedef struct packed {
        logic           rx;
        noc_pkg::flit_t data;
    } src_word_t;

    typedef logic [8:0] task_cnt_t;
    typedef logic [7:0] task_idx_t;

endpackage

// File: verilog/inject_ctrl.sv
`timescale 1ns/1ps

module inject_ctrl #(
    parameter int MAX_PAYLOAD_SIZE = 32
) (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  injector_pkg::src_word_t               src_i,
    output logic                                  src_credit_o,
    input  logic [15:0]                           mapper_address_i,
    output logic                                  listen_o,
    input  logic                                  alloc_i,
    input  logic                                  complete_i,
    input  noc_pkg::flit_t [MAX_PAYLOAD_SIZE-1:0] payload_i,
    input  logic                                  body_credit_i,
    output logic                                  start_o,
    output noc_pkg::header_t                      header_o,
    input  logic                                  done_i
);

    typedef enum logic [3:0] {
        IDLE,
        WAIT_ALLOC,
        RX_TEXT,
        RX_DATA,
        RX_BSS,
        RX_ENTRY,
        SEND,
        NEXT_TASK,
        WAIT_COMPLETE
    } state_t;

    state_t                  state_q;
    state_t                  state_d;
    injector_pkg::task_cnt_t task_cnt_q;
    injector_pkg::task_idx_t cur_task_q;
    logic                    start_q;
    noc_pkg::header_t        header_q;
    logic                    take;
    logic                    last_task;

    assign take      = src_i.rx && src_credit_o;
    assign last_task = {1'b0, cur_task_q} == task_cnt_q - 9'd1;
    assign listen_o  = state_q inside {WAIT_ALLOC, WAIT_COMPLETE};
    assign start_o   = start_q;
    assign header_o  = header_q;

    always_comb begin
        case (state_q)
            IDLE, RX_TEXT, RX_DATA, RX_BSS, RX_ENTRY: src_credit_o = 1'b1;
            SEND:    src_credit_o = body_credit_i;   // Body words only
            default: src_credit_o = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:          if (take) state_d = WAIT_ALLOC;
            WAIT_ALLOC:    if (alloc_i) state_d = RX_TEXT;
            RX_TEXT:       if (take) state_d = RX_DATA;
            RX_DATA:       if (take) state_d = RX_BSS;
            RX_BSS:        if (take) state_d = RX_ENTRY;
            RX_ENTRY:      if (take) state_d = SEND;
            SEND:          if (done_i) state_d = NEXT_TASK;
            NEXT_TASK:     state_d = last_task ? WAIT_COMPLETE : RX_TEXT;
            WAIT_COMPLETE: if (complete_i) state_d = IDLE;
            default:       state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            task_cnt_q <= '0;
            cur_task_q <= '0;
            start_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            start_q <= (state_q == RX_ENTRY) && take;   // Header complete next cycle
            if (state_q == IDLE && take) begin
                task_cnt_q <= src_i.data[8:0];
            end
            if (state_q == WAIT_ALLOC) begin
                cur_task_q <= '0;
            end else if (state_q == NEXT_TASK && !last_task) begin
                cur_task_q <= cur_task_q + 8'd1;
            end
        end
    end

    // Size flit accumulates text + data, then becomes the payload length
    always_ff @(posedge clk_i) begin
        if (take) begin
            case (state_q)
                RX_TEXT: begin
                    header_q                           <= '0;
                    header_q[noc_pkg::HDR_TARGET]      <= payload_i[cur_task_q + 8'd2];
                    header_q[noc_pkg::HDR_SIZE]        <= src_i.data;
                    header_q[noc_pkg::HDR_SERVICE]     <= noc_pkg::TASK_ALLOCATION;
                    header_q[noc_pkg::HDR_TASK_ID]     <= {16'b0, payload_i[1][7:0], cur_task_q};
                    header_q[noc_pkg::HDR_MAPPER_ADDR] <= noc_pkg::flit_t'(mapper_address_i);
                    header_q[noc_pkg::HDR_TEXT_SZ]     <= src_i.data;
                end
                RX_DATA: begin
                    header_q[noc_pkg::HDR_DATA_SZ] <= src_i.data;
                    header_q[noc_pkg::HDR_SIZE]    <= header_q[noc_pkg::HDR_SIZE] + src_i.data;
                end
                RX_BSS: header_q[noc_pkg::HDR_BSS_SZ] <= src_i.data;
                RX_ENTRY: begin
                    header_q[noc_pkg::HDR_ENTRY] <= src_i.data;
                    // Bytes to flits, plus header flits after the size flit
                    header_q[noc_pkg::HDR_SIZE] <= (header_q[noc_pkg::HDR_SIZE] >> 2)
                        + noc_pkg::flit_t'(noc_pkg::HEADER_SIZE - 2);
                end
                default: ;
            endcase
        end
    end

endmodule

// File: verilog/packet_sender.sv
`timescale 1ns/1ps

module packet_sender (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    start_i,
    input  noc_pkg::header_t        header_i,
    output logic                    done_o,
    input  injector_pkg::src_word_t src_i,
    output logic                    body_credit_o,
    output noc_pkg::noc_link_t      noc_o,
    input  logic                    noc_credit_i
);

    localparam int IDX_W = $clog2(noc_pkg::HEADER_SIZE);

    noc_pkg::header_t hdr_q;
    noc_pkg::flit_t   cnt_q;       // Flits sent so far
    logic             busy_q;
    logic             hdr_phase;
    logic             tx;
    logic             take;
    logic             last;

    assign hdr_phase = cnt_q < noc_pkg::flit_t'(noc_pkg::HEADER_SIZE);
    assign tx        = busy_q && (hdr_phase || src_i.rx);
    assign take      = tx && noc_credit_i;
    // Packet is size + 2 flits
    assign last      = cnt_q == hdr_q[noc_pkg::HDR_SIZE] + 32'd1;
    assign done_o    = take && last;

    assign body_credit_o = busy_q && !hdr_phase && noc_credit_i;

    assign noc_o.tx   = tx;
    assign noc_o.data = hdr_phase ? hdr_q[cnt_q[IDX_W-1:0]] : src_i.data;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (take) begin
            cnt_q <= cnt_q + 32'd1;
            if (last) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            hdr_q <= header_i;
        end
    end

endmodule

// File: verilog/packet_receiver.sv
`timescale 1ns/1ps

module packet_receiver #(
    parameter int MAX_PAYLOAD_SIZE = 32
) (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic                                  listen_i,
    input  noc_pkg::noc_link_t                    noc_i,
    output logic                                  noc_credit_o,
    output logic                                  alloc_o,
    output logic                                  complete_o,
    output noc_pkg::flit_t [MAX_PAYLOAD_SIZE-1:0] payload_o
);

    localparam int PIDX_W = $clog2(MAX_PAYLOAD_SIZE);
    // Size field bounds for one to MAX_PAYLOAD_SIZE payload words
    localparam noc_pkg::flit_t MIN_SIZE = noc_pkg::HEADER_SIZE - 1;
    localparam noc_pkg::flit_t MAX_SIZE = MAX_PAYLOAD_SIZE + noc_pkg::HEADER_SIZE - 2;
    localparam noc_pkg::flit_t PAY_END  = MAX_PAYLOAD_SIZE + noc_pkg::HEADER_SIZE;

    typedef enum logic [1:0] {
        IDLE,
        RECV,
        DECODE
    } state_t;

    state_t                                state_q;
    noc_pkg::flit_t                        cnt_q;
    noc_pkg::flit_t                        size_q;
    noc_pkg::flit_t                        service_q;
    noc_pkg::flit_t [MAX_PAYLOAD_SIZE-1:0] payload_q;
    noc_pkg::flit_t                        pay_off;
    logic [PIDX_W-1:0]                     pidx;
    logic                                  take;
    logic                                  last;
    logic                                  store;
    logic                                  delivery;

    assign noc_credit_o = state_q == RECV;
    assign take         = noc_i.tx && noc_credit_o;
    // Size flit is valid once two flits are in
    assign last         = take && cnt_q > 32'd1 && cnt_q == size_q + 32'd1;

    assign pay_off = cnt_q - noc_pkg::flit_t'(noc_pkg::HEADER_SIZE);
    assign pidx    = pay_off[PIDX_W-1:0];
    assign store   = take && cnt_q >= noc_pkg::flit_t'(noc_pkg::HEADER_SIZE)
        && cnt_q < PAY_END;   // Longer packets drain unstored

    assign delivery = service_q == noc_pkg::MESSAGE_DELIVERY
        && size_q >= MIN_SIZE && size_q <= MAX_SIZE;

    assign alloc_o    = state_q == DECODE && delivery
        && payload_q[0] == injector_pkg::APP_ALLOCATION_REQUEST;
    assign complete_o = state_q == DECODE && delivery
        && payload_q[0] == injector_pkg::APP_MAPPING_COMPLETE;
    assign payload_o  = payload_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (listen_i) state_q <= RECV;
                end
                RECV: begin
                    if (take) cnt_q <= cnt_q + 32'd1;
                    if (last) state_q <= DECODE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (take && cnt_q == noc_pkg::flit_t'(noc_pkg::HDR_SIZE)) begin
            size_q <= noc_i.data;
        end
        if (take && cnt_q == noc_pkg::flit_t'(noc_pkg::HDR_SERVICE)) begin
            service_q <= noc_i.data;
        end
        if (store) begin
            payload_q[pidx] <= noc_i.data;
        end
    end

endmodule

// File: verilog/task_injector.sv
`timescale 1ns/1ps

module task_injector #(
    parameter int MAX_PAYLOAD_SIZE = 32
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  injector_pkg::src_word_t src_i,
    output logic                    src_credit_o,
    input  logic [15:0]             mapper_address_i,
    output noc_pkg::noc_link_t      noc_o,
    input  logic                    noc_credit_i,
    input  noc_pkg::noc_link_t      noc_i,
    output logic                    noc_credit_o
);

    logic                                  listen;
    logic                                  alloc;
    logic                                  complete;
    noc_pkg::flit_t [MAX_PAYLOAD_SIZE-1:0] payload;
    logic                                  body_credit;
    logic                                  start;
    noc_pkg::header_t                      header;
    logic                                  done;

    inject_ctrl #(
        .MAX_PAYLOAD_SIZE(MAX_PAYLOAD_SIZE)
    ) inject_ctrl_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .src_i           (src_i),
        .src_credit_o    (src_credit_o),
        .mapper_address_i(mapper_address_i),
        .listen_o        (listen),
        .alloc_i         (alloc),
        .complete_i      (complete),
        .payload_i       (payload),
        .body_credit_i   (body_credit),
        .start_o         (start),
        .header_o        (header),
        .done_i          (done)
    );

    packet_sender packet_sender_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start),
        .header_i     (header),
        .done_o       (done),
        .src_i        (src_i),
        .body_credit_o(body_credit),
        .noc_o        (noc_o),
        .noc_credit_i (noc_credit_i)
    );

    packet_receiver #(
        .MAX_PAYLOAD_SIZE(MAX_PAYLOAD_SIZE)
    ) packet_receiver_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .listen_i    (listen),
        .noc_i       (noc_i),
        .noc_credit_o(noc_credit_o),
        .alloc_o     (alloc),
        .complete_o  (complete),
        .payload_o   (payload)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

// File: sim/task_injector_checker.sv
`timescale 1ns/1ps

module task_injector_checker (
    input logic               clk_i,
    input logic               rst_ni,
    input noc_pkg::noc_link_t noc_tx_i,
    input logic               noc_credit_i,
    input logic               rx_credit_i,
    input logic               src_credit_i
);

    int unsigned reset_fails  = 0;
    int unsigned hold_fails   = 0;
    int unsigned credit_fails = 0;

    // Both NoC directions quiet in reset
    reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !noc_tx_i.tx && !rx_credit_i)
        else begin
            $error("noc tx or noc_credit_o high during reset");
            reset_fails++;
        end

    // Uncredited flit is held for the next cycle
    flit_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        noc_tx_i.tx && !noc_credit_i |=> noc_tx_i.tx && $stable(noc_tx_i.data))
        else begin
            $error("flit changed or dropped while noc_credit_i was low");
            hold_fails++;
        end

    credit_gate: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(src_credit_i && noc_tx_i.tx && !noc_credit_i))
        else begin
            $error("source credited while the NoC output is stalled");
            credit_fails++;
        end

endmodule

// File: sim/tb_task_injector.sv
`timescale 1ns/1ps

module tb_task_injector;

    localparam int          MAX_PAYLOAD = 32;
    localparam logic [31:0] SEED        = 32'h245e1ff1;
    // Flits per test over source, NoC out and NoC in
    localparam int          TEST_FLITS  = 55 + 117 + 117 + 138;
    localparam int          WATCHDOG_NS = TEST_FLITS * 4 * 8;   // 4 cycles per flit, 8 ns clock
    localparam int          WAIT_LIMIT  = 500;

    logic                    clk;
    logic                    rst_n;
    injector_pkg::src_word_t src            = '0;
    logic                    src_credit;
    logic [15:0]             mapper_address = 16'h0105;
    noc_pkg::noc_link_t      noc_out;
    logic                    noc_credit     = 1'b1;
    noc_pkg::noc_link_t      noc_in         = '0;
    logic                    noc_in_credit;

    noc_pkg::flit_t src_q[$];   // Source words in order
    noc_pkg::flit_t map_q[$];   // Mapper flits in order
    noc_pkg::flit_t exp_q[$];
    noc_pkg::flit_t out_q[$];
    noc_pkg::flit_t tgt_q[$];   // Targets for the next allocation
    int             src_rd     = 0;
    int             map_rd     = 0;
    int             checked    = 0;
    logic           bp_en      = 1'b0;
    logic [31:0]    bp_state   = SEED;
    logic [31:0]    data_state = SEED;
    int             err_value  = 0;
    int             err_other  = 0;
    int             n_checks   = 0;
    int             asrt_fails = 0;

    tb_clock_gen #(
        .PERIOD_NS   (8),
        .RESET_CYCLES(3)
    ) clock_gen_i (
        .clk_o (clk),
        .rst_no(rst_n)
    );

    task_injector #(
        .MAX_PAYLOAD_SIZE(MAX_PAYLOAD)
    ) task_injector_i (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .src_i           (src),
        .src_credit_o    (src_credit),
        .mapper_address_i(mapper_address),
        .noc_o           (noc_out),
        .noc_credit_i    (noc_credit),
        .noc_i           (noc_in),
        .noc_credit_o    (noc_in_credit)
    );

    bind task_injector task_injector_checker checker_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .noc_tx_i    (noc_o),
        .noc_credit_i(noc_credit_i),
        .rx_credit_i (noc_credit_o),
        .src_credit_i(src_credit_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Source and mapper hold each word until credited
    always @(posedge clk) begin
        if (src.rx && src_credit) src_rd++;
        src.rx <= src_rd < src_q.size();
        if (src_rd < src_q.size()) src.data <= src_q[src_rd];
    end

    always @(posedge clk) begin
        if (noc_in.tx && noc_in_credit) map_rd++;
        noc_in.tx <= map_rd < map_q.size();
        if (map_rd < map_q.size()) noc_in.data <= map_q[map_rd];
    end

    always @(posedge clk) begin
        if (noc_out.tx && noc_credit) out_q.push_back(noc_out.data);
    end

    always @(posedge clk) begin
        if (bp_en) begin
            bp_state = lcg_next(bp_state);
            noc_credit <= bp_state[31:30] != 2'b00;   // About 3 in 4
        end else begin
            noc_credit <= 1'b1;
        end
    end

    task automatic check_flit(input string name, input noc_pkg::flit_t got,
                              input noc_pkg::flit_t exp);
        n_checks++;
        if (got !== exp) begin
            err_value++;
            $display("** Error: %s = %h, expected %h (%0t)", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            err_value++;
            $display("** Error: %s = %h, expected %h (%0t)", name, got, exp, $time);
        end
    endtask

    task automatic note_failure(input string what);
        err_other++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    task automatic queue_task(input noc_pkg::flit_t app_id, input int k,
                              input noc_pkg::flit_t target, input noc_pkg::flit_t text_sz,
                              input noc_pkg::flit_t data_sz, input noc_pkg::flit_t bss_sz,
                              input noc_pkg::flit_t entry);
        noc_pkg::header_t hdr;
        int               body;
        hdr = '0;
        hdr[noc_pkg::HDR_TARGET]      = target;
        hdr[noc_pkg::HDR_SIZE]        = ((text_sz + data_sz) >> 2) + 32'd11;
        hdr[noc_pkg::HDR_SERVICE]     = noc_pkg::TASK_ALLOCATION;
        hdr[noc_pkg::HDR_TASK_ID]     = {16'h0, app_id[7:0], k[7:0]};
        hdr[noc_pkg::HDR_MAPPER_ADDR] = {16'h0, mapper_address};
        hdr[noc_pkg::HDR_DATA_SZ]     = data_sz;
        hdr[noc_pkg::HDR_TEXT_SZ]     = text_sz;
        hdr[noc_pkg::HDR_BSS_SZ]      = bss_sz;
        hdr[noc_pkg::HDR_ENTRY]       = entry;
        src_q.push_back(text_sz);
        src_q.push_back(data_sz);
        src_q.push_back(bss_sz);
        src_q.push_back(entry);
        tgt_q.push_back(target);
        for (int i = 0; i < noc_pkg::HEADER_SIZE; i++) exp_q.push_back(hdr[i]);
        body = int'((text_sz + data_sz) >> 2);
        for (int i = 0; i < body; i++) begin   // Binary passes through unchanged
            data_state = lcg_next(data_state);
            src_q.push_back(data_state);
            exp_q.push_back(data_state);
        end
    endtask

    task automatic queue_header(input noc_pkg::flit_t service, input int words);
        map_q.push_back(32'h0);
        map_q.push_back(32'(11 + words));
        map_q.push_back(service);
        for (int i = 3; i < noc_pkg::HEADER_SIZE; i++) map_q.push_back(32'h0);
    endtask

    // Mapper delivery carrying application code, id and pending targets
    task automatic send_delivery(input noc_pkg::flit_t code, input noc_pkg::flit_t app_id);
        queue_header(noc_pkg::MESSAGE_DELIVERY, 2 + tgt_q.size());
        map_q.push_back(code);
        map_q.push_back(app_id);
        foreach (tgt_q[i]) map_q.push_back(tgt_q[i]);
        tgt_q.delete();
    endtask

    task automatic wait_output();
        int cycles;
        cycles = 0;
        while (out_q.size() < exp_q.size() && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (out_q.size() < exp_q.size())
            note_failure($sformatf("only %0d of %0d flits left on noc_o",
                                   out_q.size(), exp_q.size()));
        for (int i = checked; i < exp_q.size() && i < out_q.size(); i++)
            check_flit($sformatf("noc_o.data[%0d]", i), out_q[i], exp_q[i]);
        checked = exp_q.size();
    endtask

    task automatic wait_mapper_drained();
        int cycles;
        cycles = 0;
        while (map_rd < map_q.size() && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (map_rd < map_q.size()) note_failure("mapper packets were not taken by the DUT");
    endtask

    task automatic finish_app(input noc_pkg::flit_t app_id);
        int cycles;
        send_delivery(injector_pkg::APP_MAPPING_COMPLETE, app_id);
        wait_mapper_drained();
        cycles = 0;
        while (!src_credit && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!src_credit) note_failure("src_credit_o stayed low after the completion delivery");
        if (out_q.size() != exp_q.size()) note_failure("extra flits appeared on noc_o");
    endtask

    task automatic test_reset_state();
        check_bit("noc_o.tx", noc_out.tx, 1'b0);
        check_bit("noc_credit_o", noc_in_credit, 1'b0);
        check_bit("src_credit_o", src_credit, 1'b1);
    endtask

    task automatic test_single_task();
        src_q.push_back(32'd1);
        queue_task(32'h11, 0, 32'h0102, 32'd8, 32'd4, 32'd2, 32'h100);
        send_delivery(injector_pkg::APP_ALLOCATION_REQUEST, 32'h11);
        wait_output();
        finish_app(32'h11);
    endtask

    task automatic test_back_pressure();
        bp_en = 1'b1;
        src_q.push_back(32'd3);
        queue_task(32'h23, 0, 32'h0201, 32'd16, 32'd8, 32'd4, 32'h200);
        queue_task(32'h23, 1, 32'h0302, 32'd4, 32'd4, 32'd0, 32'h300);
        queue_task(32'h23, 2, 32'h0403, 32'd12, 32'd20, 32'd8, 32'h400);
        send_delivery(injector_pkg::APP_ALLOCATION_REQUEST, 32'h23);
        wait_output();
        bp_en = 1'b0;
        finish_app(32'h23);
    endtask

    task automatic test_ignored_input();
        src_q.push_back(32'd1);
        queue_task(32'h34, 0, 32'h0504, 32'd4, 32'd8, 32'd16, 32'h500);
        queue_header(32'h2, 3);   // Unknown service
        map_q.push_back(injector_pkg::APP_ALLOCATION_REQUEST);
        map_q.push_back(32'h34);
        map_q.push_back(32'h0999);
        queue_header(noc_pkg::MESSAGE_DELIVERY, MAX_PAYLOAD + 1);
        map_q.push_back(injector_pkg::APP_ALLOCATION_REQUEST);
        for (int i = 1; i <= MAX_PAYLOAD; i++) map_q.push_back(32'(i));
        wait_mapper_drained();
        repeat (4) @(negedge clk);
        if (out_q.size() != checked) note_failure("ignored packet started an injection");
        check_bit("src_credit_o", src_credit, 1'b0);
        send_delivery(injector_pkg::APP_ALLOCATION_REQUEST, 32'h34);
        wait_output();
        finish_app(32'h34);
    endtask

    task automatic test_completion();
        src_q.push_back(32'd2);
        queue_task(32'h45, 0, 32'h0601, 32'd8, 32'd8, 32'd4, 32'h600);
        queue_task(32'h45, 1, 32'h0702, 32'd4, 32'd0, 32'd0, 32'h700);
        send_delivery(injector_pkg::APP_ALLOCATION_REQUEST, 32'h45);
        wait_output();
        repeat (3) @(negedge clk);
        check_bit("src_credit_o", src_credit, 1'b0);      // Waiting for completion
        check_bit("noc_credit_o", noc_in_credit, 1'b1);
        finish_app(32'h45);
        src_q.push_back(32'd1);
        queue_task(32'h56, 0, 32'h0803, 32'd20, 32'd4, 32'd12, 32'h800);
        send_delivery(injector_pkg::APP_ALLOCATION_REQUEST, 32'h56);
        wait_output();
        finish_app(32'h56);
    endtask

    initial begin
        @(posedge rst_n);
        @(negedge clk);
        test_reset_state();
        test_single_task();
        test_back_pressure();
        test_ignored_input();
        test_completion();
        repeat (4) @(negedge clk);
        asrt_fails = int'(task_injector_i.checker_i.reset_fails
            + task_injector_i.checker_i.hold_fails + task_injector_i.checker_i.credit_fails);
        $display("Checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 n_checks, err_value, err_other, asrt_fails);
        if (err_value + err_other + asrt_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: task_injector.f
verilog/noc_pkg.sv
verilog/injector_pkg.sv
verilog/inject_ctrl.sv
verilog/packet_sender.sv
verilog/packet_receiver.sv
verilog/task_injector.sv
sim/tb_clock_gen.sv
sim/task_injector_checker.sv
sim/tb_task_injector.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_task_injector \
    -f task_injector.f -Mdir obj_dir -o sim_task_injector
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_task_injector +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
